// ==== backend_config.svh ====
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// width of a result word and of an instruction address
`define DATA_WIDTH 32

// register file destination address
`define REG_ADDR_WIDTH 5

// reorder buffer entries, any power of two
`define ROB_DEPTH 16

// log2 of the depth
`define ROB_TAG_WIDTH 4

// base of the vectored handler table
`define TRAP_VECTOR_BASE 32'h0000_0100

`endif

// ==== backend_pkg.sv ====
`include "backend_config.svh"

package backend_pkg;

    // result and address word
    typedef logic [`DATA_WIDTH-1:0] data_word_t;

    // number of execution units feeding the commit stage
    localparam int unsigned EXU_COUNT = 3;

    // cause codes follow the machine mode encoding
    // EXC_NONE sits on 15, which the retire stage never reports
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGNED = 4'd0,
        EXC_ILLEGAL_INSTR    = 4'd2,
        EXC_LOAD_MISALIGNED  = 4'd4,
        EXC_STORE_MISALIGNED = 4'd6,
        EXC_ENV_CALL         = 4'd11,
        EXC_NONE             = 4'd15
    } exc_cause_t;

    // also the slot index inside the commit stage
    typedef enum logic [1:0] {
        UNIT_ITU = 2'd0,  // integer unit
        UNIT_LSU = 2'd1,  // load/store unit
        UNIT_CSR = 2'd2   // csr unit
    } exu_unit_t;

    typedef enum logic {
        RETIRE_RUN   = 1'b0,  // normal in-order writeback
        RETIRE_FLUSH = 1'b1   // one cycle pipeline flush after a trap
    } retire_state_t;

endpackage : backend_pkg

// ==== backend_if.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

// commit stage to reorder buffer, one result per cycle
interface rob_write_if import backend_pkg::*; ();

    logic                      write;
    logic [`ROB_TAG_WIDTH-1:0] tag;
    data_word_t                result;
    logic                      exception;
    exc_cause_t                cause;

    modport master (output write, tag, result, exception, cause);
    modport slave  (input  write, tag, result, exception, cause);

endinterface : rob_write_if

// reorder buffer head to retire stage
interface rob_head_if import backend_pkg::*; ();

    logic                       valid;      // head allocated and done
    logic [`REG_ADDR_WIDTH-1:0] dest;
    data_word_t                 result;
    data_word_t                 pc;
    logic                       exception;
    exc_cause_t                 cause;
    logic                       read;       // pops the head with valid

    modport master (output valid, dest, result, pc, exception, cause, input read);
    modport slave  (input  valid, dest, result, pc, exception, cause, output read);

endinterface : rob_head_if

// ==== commit_stage.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module commit_stage import backend_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    input  logic                      itu_valid_i,
    input  logic [`ROB_TAG_WIDTH-1:0] itu_tag_i,
    input  data_word_t                itu_result_i,
    input  logic                      itu_exception_i,
    input  exc_cause_t                itu_cause_i,
    output logic                      itu_ready_o,

    input  logic                      lsu_valid_i,
    input  logic [`ROB_TAG_WIDTH-1:0] lsu_tag_i,
    input  data_word_t                lsu_result_i,
    input  logic                      lsu_exception_i,
    input  exc_cause_t                lsu_cause_i,
    output logic                      lsu_ready_o,

    input  logic                      csr_valid_i,
    input  logic [`ROB_TAG_WIDTH-1:0] csr_tag_i,
    input  data_word_t                csr_result_i,
    input  logic                      csr_exception_i,
    input  exc_cause_t                csr_cause_i,
    output logic                      csr_ready_o,

    rob_write_if.master               rob_wr
);

    logic [EXU_COUNT-1:0]      in_valid;
    logic [`ROB_TAG_WIDTH-1:0] in_tag       [EXU_COUNT];
    data_word_t                in_result    [EXU_COUNT];
    logic [EXU_COUNT-1:0]      in_exception;
    exc_cause_t                in_cause     [EXU_COUNT];

    logic [EXU_COUNT-1:0]      slot_valid;
    logic [`ROB_TAG_WIDTH-1:0] slot_tag     [EXU_COUNT];
    data_word_t                slot_result  [EXU_COUNT];
    logic [EXU_COUNT-1:0]      slot_exception;
    exc_cause_t                slot_cause   [EXU_COUNT];

    exu_unit_t                 sel;
    logic [EXU_COUNT-1:0]      grant;
    logic [EXU_COUNT-1:0]      ready;
    logic [EXU_COUNT-1:0]      accept;

    // gather the unit ports into slot-indexed arrays
    assign in_valid     = {csr_valid_i, lsu_valid_i, itu_valid_i};
    assign in_exception = {csr_exception_i, lsu_exception_i, itu_exception_i};

    assign in_tag[UNIT_ITU]    = itu_tag_i;
    assign in_tag[UNIT_LSU]    = lsu_tag_i;
    assign in_tag[UNIT_CSR]    = csr_tag_i;
    assign in_result[UNIT_ITU] = itu_result_i;
    assign in_result[UNIT_LSU] = lsu_result_i;
    assign in_result[UNIT_CSR] = csr_result_i;
    assign in_cause[UNIT_ITU]  = itu_cause_i;
    assign in_cause[UNIT_LSU]  = lsu_cause_i;
    assign in_cause[UNIT_CSR]  = csr_cause_i;

    always_comb begin
        if (slot_valid[UNIT_ITU]) begin
            sel = UNIT_ITU;
        end else if (slot_valid[UNIT_LSU]) begin
            sel = UNIT_LSU;
        end else begin
            sel = UNIT_CSR;  // also the idle default
        end
        grant      = '0;
        grant[sel] = slot_valid[sel];
    end

    assign ready  = ~slot_valid | grant;  // empty or leaving this cycle
    assign accept = in_valid & ready;

    assign itu_ready_o = ready[UNIT_ITU];
    assign lsu_ready_o = ready[UNIT_LSU];
    assign csr_ready_o = ready[UNIT_CSR];

    assign rob_wr.write     = |slot_valid;
    assign rob_wr.tag       = slot_tag[sel];
    assign rob_wr.result    = slot_result[sel];
    assign rob_wr.exception = slot_exception[sel];
    assign rob_wr.cause     = slot_cause[sel];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            slot_valid <= '0;  // younger results are dropped on a flush
        end else begin
            for (int u = 0; u < EXU_COUNT; u++) begin
                if (accept[u]) begin
                    slot_valid[u] <= 1'b1;
                end else if (grant[u]) begin
                    slot_valid[u] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int u = 0; u < EXU_COUNT; u++) begin
            if (accept[u]) begin
                slot_tag[u]       <= in_tag[u];
                slot_result[u]    <= in_result[u];
                slot_exception[u] <= in_exception[u];
                slot_cause[u]     <= in_cause[u];
            end
        end
    end

    // the issue side hands out each tag once, so pending slots never collide
    a_distinct_slot_tags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(slot_valid[UNIT_ITU] && slot_valid[UNIT_LSU] &&
          slot_tag[UNIT_ITU] == slot_tag[UNIT_LSU]) &&
        !(slot_valid[UNIT_ITU] && slot_valid[UNIT_CSR] &&
          slot_tag[UNIT_ITU] == slot_tag[UNIT_CSR]) &&
        !(slot_valid[UNIT_LSU] && slot_valid[UNIT_CSR] &&
          slot_tag[UNIT_LSU] == slot_tag[UNIT_CSR]));

endmodule : commit_stage

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module reorder_buffer import backend_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       clear_i,

    input  logic                       alloc_valid_i,
    input  logic [`REG_ADDR_WIDTH-1:0] alloc_dest_i,
    input  data_word_t                 alloc_pc_i,
    output logic                       alloc_ready_o,
    output logic [`ROB_TAG_WIDTH-1:0]  alloc_tag_o,

    rob_write_if.slave                 rob_wr,
    rob_head_if.master                 rob_head
);

    logic [`ROB_DEPTH-1:0]      busy;   // allocated, not yet retired
    logic [`ROB_DEPTH-1:0]      done;   // result written

    logic [`REG_ADDR_WIDTH-1:0] entry_dest      [`ROB_DEPTH];
    data_word_t                 entry_pc        [`ROB_DEPTH];
    data_word_t                 entry_result    [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]      entry_exception;
    exc_cause_t                 entry_cause     [`ROB_DEPTH];

    logic [`ROB_TAG_WIDTH-1:0]  head_ptr;
    logic [`ROB_TAG_WIDTH-1:0]  tail_ptr;
    logic [`ROB_TAG_WIDTH:0]    count;    // one extra bit to tell full from empty

    logic                       alloc;
    logic                       pop;

    // no allocation in the flush cycle, it would be cleared at the same edge
    assign alloc_ready_o = (count != `ROB_DEPTH) && !clear_i;
    assign alloc_tag_o   = tail_ptr;

    assign alloc = alloc_valid_i && alloc_ready_o;
    assign pop   = rob_head.valid && rob_head.read;

    assign rob_head.valid     = busy[head_ptr] && done[head_ptr];
    assign rob_head.dest      = entry_dest[head_ptr];
    assign rob_head.result    = entry_result[head_ptr];
    assign rob_head.pc        = entry_pc[head_ptr];
    assign rob_head.exception = entry_exception[head_ptr];
    assign rob_head.cause     = entry_cause[head_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            busy     <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;  // restart hands out tag 0 first
            count    <= '0;
        end else begin
            if (alloc) begin
                busy[tail_ptr] <= 1'b1;
                done[tail_ptr] <= 1'b0;
                tail_ptr       <= tail_ptr + 1'b1;  // wraps at depth
            end

            if (rob_wr.write) begin
                done[rob_wr.tag] <= 1'b1;  // completes out of order
            end

            if (pop) begin
                busy[head_ptr] <= 1'b0;
                done[head_ptr] <= 1'b0;
                head_ptr       <= head_ptr + 1'b1;
            end

            case ({alloc, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            entry_dest[tail_ptr] <= alloc_dest_i;
            entry_pc[tail_ptr]   <= alloc_pc_i;
        end
        if (rob_wr.write) begin
            entry_result[rob_wr.tag]    <= rob_wr.result;
            entry_exception[rob_wr.tag] <= rob_wr.exception;
            entry_cause[rob_wr.tag]     <= rob_wr.cause;
        end
    end

    // commit stage results only ever target entries the issue side allocated
    a_write_to_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rob_wr.write |-> busy[rob_wr.tag]);

    // retire pops only what the buffer holds
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop |-> count != '0);

endmodule : reorder_buffer

// ==== retire_stage.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module retire_stage import backend_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    rob_head_if.slave                  rob_head,

    output logic                       writeback_o,
    output logic [`REG_ADDR_WIDTH-1:0] reg_dest_o,
    output data_word_t                 result_o,

    output logic                       trap_o,
    output exc_cause_t                 trap_cause_o,
    output data_word_t                 trap_epc_o,
    output data_word_t                 handler_pc_o,

    output logic                       flush_o
);

    retire_state_t state;
    logic          take_trap;
    data_word_t    handler_pc;

    assign writeback_o = (state == RETIRE_RUN) && rob_head.valid && !rob_head.exception;
    assign take_trap   = (state == RETIRE_RUN) && rob_head.valid && rob_head.exception;

    assign rob_head.read = writeback_o;  // the excepting head is cleared and never popped
    assign reg_dest_o    = rob_head.dest;
    assign result_o      = rob_head.result;

    assign flush_o = (state == RETIRE_FLUSH);

    // vectored mode with one word per cause
    assign handler_pc = data_word_t'(`TRAP_VECTOR_BASE) + data_word_t'({rob_head.cause, 2'b00});

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state  <= RETIRE_RUN;
            trap_o <= 1'b0;
        end else begin
            case (state)
                RETIRE_RUN: begin
                    if (take_trap) begin
                        state <= RETIRE_FLUSH;
                    end
                end
                RETIRE_FLUSH: begin
                    state <= RETIRE_RUN;  // single flush cycle
                end
                default: begin
                    state <= RETIRE_RUN;
                end
            endcase
            trap_o <= take_trap;  // lines up with the flush cycle
        end
    end

    // trap record that holds until the next trap
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            trap_cause_o <= EXC_NONE;
            trap_epc_o   <= '0;
            handler_pc_o <= '0;
        end else if (take_trap) begin
            trap_cause_o <= rob_head.cause;
            trap_epc_o   <= rob_head.pc;
            handler_pc_o <= handler_pc;
        end
    end

    // younger entries never reach writeback once the flush is done
    a_rob_empty_after_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_o |=> !rob_head.valid);

endmodule : retire_stage

// ==== back_end.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module back_end import backend_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       issue_valid_i,
    input  logic [`REG_ADDR_WIDTH-1:0] issue_dest_i,
    input  data_word_t                 issue_pc_i,
    output logic                       issue_ready_o,
    output logic [`ROB_TAG_WIDTH-1:0]  issue_tag_o,

    input  logic                       itu_valid_i,
    input  logic [`ROB_TAG_WIDTH-1:0]  itu_tag_i,
    input  data_word_t                 itu_result_i,
    input  logic                       itu_exception_i,
    input  exc_cause_t                 itu_cause_i,
    output logic                       itu_ready_o,

    input  logic                       lsu_valid_i,
    input  logic [`ROB_TAG_WIDTH-1:0]  lsu_tag_i,
    input  data_word_t                 lsu_result_i,
    input  logic                       lsu_exception_i,
    input  exc_cause_t                 lsu_cause_i,
    output logic                       lsu_ready_o,

    input  logic                       csr_valid_i,
    input  logic [`ROB_TAG_WIDTH-1:0]  csr_tag_i,
    input  data_word_t                 csr_result_i,
    input  logic                       csr_exception_i,
    input  exc_cause_t                 csr_cause_i,
    output logic                       csr_ready_o,

    output logic                       writeback_o,
    output logic [`REG_ADDR_WIDTH-1:0] reg_destination_o,
    output data_word_t                 writeback_result_o,

    output logic                       trap_o,
    output exc_cause_t                 trap_cause_o,
    output data_word_t                 trap_epc_o,
    output data_word_t                 handler_pc_o,
    output logic                       flush_pipeline_o
);

    logic flush_pipeline;  // clears the ROB and the commit slots

    rob_write_if rob_wr ();
    rob_head_if  rob_head ();

    commit_stage commit (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .flush_i         ( flush_pipeline  ),
        .itu_valid_i     ( itu_valid_i     ),
        .itu_tag_i       ( itu_tag_i       ),
        .itu_result_i    ( itu_result_i    ),
        .itu_exception_i ( itu_exception_i ),
        .itu_cause_i     ( itu_cause_i     ),
        .itu_ready_o     ( itu_ready_o     ),
        .lsu_valid_i     ( lsu_valid_i     ),
        .lsu_tag_i       ( lsu_tag_i       ),
        .lsu_result_i    ( lsu_result_i    ),
        .lsu_exception_i ( lsu_exception_i ),
        .lsu_cause_i     ( lsu_cause_i     ),
        .lsu_ready_o     ( lsu_ready_o     ),
        .csr_valid_i     ( csr_valid_i     ),
        .csr_tag_i       ( csr_tag_i       ),
        .csr_result_i    ( csr_result_i    ),
        .csr_exception_i ( csr_exception_i ),
        .csr_cause_i     ( csr_cause_i     ),
        .csr_ready_o     ( csr_ready_o     ),
        .rob_wr          ( rob_wr          )
    );

    reorder_buffer rob (
        .clk_i         ( clk_i          ),
        .rst_n_i       ( rst_n_i        ),
        .clear_i       ( flush_pipeline ),
        .alloc_valid_i ( issue_valid_i  ),
        .alloc_dest_i  ( issue_dest_i   ),
        .alloc_pc_i    ( issue_pc_i     ),
        .alloc_ready_o ( issue_ready_o  ),
        .alloc_tag_o   ( issue_tag_o    ),
        .rob_wr        ( rob_wr         ),
        .rob_head      ( rob_head       )
    );

    retire_stage retire (
        .clk_i        ( clk_i              ),
        .rst_n_i      ( rst_n_i            ),
        .rob_head     ( rob_head           ),
        .writeback_o  ( writeback_o        ),
        .reg_dest_o   ( reg_destination_o  ),
        .result_o     ( writeback_result_o ),
        .trap_o       ( trap_o             ),
        .trap_cause_o ( trap_cause_o       ),
        .trap_epc_o   ( trap_epc_o         ),
        .handler_pc_o ( handler_pc_o       ),
        .flush_o      ( flush_pipeline     )
    );

    assign flush_pipeline_o = flush_pipeline;

endmodule : back_end

// ==== tb_back_end.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module tb_back_end import backend_pkg::*; ();

    localparam int N_TOTAL     = `ROB_DEPTH + 300;  // full-buffer fill plus random traffic
    localparam int CYCLE_LIMIT = 20 * N_TOTAL + 200;

    typedef struct packed {
        logic [`ROB_TAG_WIDTH-1:0]  tag;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        data_word_t                 pc;
        data_word_t                 result;
        logic                       exc;
        exc_cause_t                 cause;
        logic                       sent;      // handed to a unit
        logic                       accepted;  // unit result taken by the DUT
    } model_entry_t;

    logic                       clk_i = 1'b0;
    logic                       rst_n_i;
    logic                       issue_valid_i;
    logic [`REG_ADDR_WIDTH-1:0] issue_dest_i;
    data_word_t                 issue_pc_i;
    logic                       issue_ready_o;
    logic [`ROB_TAG_WIDTH-1:0]  issue_tag_o;
    logic                       writeback_o;
    logic [`REG_ADDR_WIDTH-1:0] reg_destination_o;
    data_word_t                 writeback_result_o;
    logic                       trap_o;
    exc_cause_t                 trap_cause_o;
    data_word_t                 trap_epc_o;
    data_word_t                 handler_pc_o;
    logic                       flush_pipeline_o;

    // unit side indexed as itu 0, lsu 1 and csr 2
    logic [2:0]                 u_valid;
    logic [`ROB_TAG_WIDTH-1:0]  u_tag    [3];
    data_word_t                 u_result [3];
    logic [2:0]                 u_exc;
    exc_cause_t                 u_cause  [3];
    wire  [2:0]                 u_ready;

    model_entry_t               model [$];  // issued entries in program order
    logic [`ROB_TAG_WIDTH-1:0]  next_tag = '0;
    logic [31:0]                rand_state = 32'd67856;
    int                         cycles = 0;
    int                         issued = 0;
    int                         retired = 0;
    int                         traps = 0;
    int                         all_three = 0;  // cycles with every unit presenting

    back_end uut (
        .*,
        .itu_valid_i     ( u_valid[0]  ),
        .itu_tag_i       ( u_tag[0]    ),
        .itu_result_i    ( u_result[0] ),
        .itu_exception_i ( u_exc[0]    ),
        .itu_cause_i     ( u_cause[0]  ),
        .itu_ready_o     ( u_ready[0]  ),
        .lsu_valid_i     ( u_valid[1]  ),
        .lsu_tag_i       ( u_tag[1]    ),
        .lsu_result_i    ( u_result[1] ),
        .lsu_exception_i ( u_exc[1]    ),
        .lsu_cause_i     ( u_cause[1]  ),
        .lsu_ready_o     ( u_ready[1]  ),
        .csr_valid_i     ( u_valid[2]  ),
        .csr_tag_i       ( u_tag[2]    ),
        .csr_result_i    ( u_result[2] ),
        .csr_exception_i ( u_exc[2]    ),
        .csr_cause_i     ( u_cause[2]  ),
        .csr_ready_o     ( u_ready[2]  )
    );

    always #5 clk_i = ~clk_i;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s expected %h got %h at %0t", name, expected, actual, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    // vectored handler with one word per cause code
    function automatic data_word_t expected_handler(input exc_cause_t cause);
        return data_word_t'(`TRAP_VECTOR_BASE) + 32'(cause) * 32'd4;
    endfunction

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {16'h0000, rand_state[30:15]};  // upper bits since the low ones cycle fast
    endfunction

    function automatic int find_tag(input logic [`ROB_TAG_WIDTH-1:0] tag);
        foreach (model[i]) begin
            if (model[i].tag == tag) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic drive_issue(input logic valid);
        issue_valid_i = valid;
        issue_dest_i  = `REG_ADDR_WIDTH'(next_random());
        issue_pc_i    = 32'h0000_1000 + 32'(issued) * 32'd4;
    endtask

    task automatic send_result(input int u, input int idx, input logic allow_exc);
        exc_cause_t causes [5] = '{EXC_INSTR_MISALIGNED, EXC_ILLEGAL_INSTR,
                                   EXC_LOAD_MISALIGNED, EXC_STORE_MISALIGNED, EXC_ENV_CALL};
        model[idx].sent = 1'b1;
        u_valid[u]  = 1'b1;
        u_tag[u]    = model[idx].tag;
        u_result[u] = (next_random() << 16) ^ next_random();
        u_exc[u]    = allow_exc && (next_random() % 40 == 0);
        u_cause[u]  = u_exc[u] ? causes[3'(next_random() % 5)] : EXC_NONE;
    endtask

    // a unit holds its result until taken and then may pick another outstanding tag
    task automatic step_units(input logic allow_new);
        int idx;
        int pick [$];
        for (int u = 0; u < 3; u++) begin
            if (u_valid[u]) begin
                idx = find_tag(u_tag[u]);
                if (idx < 0 || model[idx].accepted) begin
                    u_valid[u] = 1'b0;  // taken or flushed
                end
            end
            if (!u_valid[u] && allow_new && next_random() % 4 != 0) begin
                pick.delete();
                foreach (model[i]) begin
                    if (!model[i].sent) begin
                        pick.push_back(i);
                    end
                end
                if (pick.size() != 0) begin
                    send_result(u, pick[next_random() % pick.size()], 1'b1);
                end
            end
        end
    endtask

    always @(posedge clk_i) begin
        int idx;
        if (rst_n_i) begin
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("timeout after %0d cycles, retirement did not finish", cycles);
                $display("Errors found");
                $fatal(1);
            end
            if (&u_valid) begin
                all_three++;
            end
            assert (flush_pipeline_o == trap_o)
                else report_mismatch("flush_pipeline_o", 32'(trap_o), 32'(flush_pipeline_o));
            if (writeback_o) begin
                assert (model.size() != 0)
                    else report_failure("writeback while no instruction is outstanding");
                assert (model[0].accepted && !model[0].exc)
                    else report_failure("writeback of the head without a clean accepted result");
                assert (reg_destination_o == model[0].dest)
                    else report_mismatch("reg_destination_o", 32'(model[0].dest),
                                         32'(reg_destination_o));
                assert (writeback_result_o == model[0].result)
                    else report_mismatch("writeback_result_o", model[0].result,
                                         writeback_result_o);
                void'(model.pop_front());
                retired++;
            end
            if (trap_o) begin
                assert (model.size() != 0 && model[0].accepted && model[0].exc)
                    else report_failure("trap without an excepting instruction at the head");
                assert (trap_cause_o == model[0].cause)
                    else report_mismatch("trap_cause_o", 32'(model[0].cause), 32'(trap_cause_o));
                assert (trap_epc_o == model[0].pc)
                    else report_mismatch("trap_epc_o", model[0].pc, trap_epc_o);
                assert (handler_pc_o == expected_handler(model[0].cause))
                    else report_mismatch("handler_pc_o", expected_handler(model[0].cause),
                                         handler_pc_o);
                model.delete();  // younger instructions are discarded
                next_tag = '0;
                traps++;
            end
            if (issue_valid_i && issue_ready_o) begin
                assert (issue_tag_o == next_tag)
                    else report_mismatch("issue_tag_o", 32'(next_tag), 32'(issue_tag_o));
                model.push_back('{tag: issue_tag_o, dest: issue_dest_i, pc: issue_pc_i,
                                  result: '0, exc: 1'b0, cause: EXC_NONE,
                                  sent: 1'b0, accepted: 1'b0});
                next_tag++;
                issued++;
            end
            for (int u = 0; u < 3; u++) begin
                idx = find_tag(u_tag[u]);
                if (u_valid[u] && u_ready[u] && idx >= 0) begin
                    model[idx].accepted = 1'b1;
                    model[idx].result   = u_result[u];
                    model[idx].exc      = u_exc[u];
                    model[idx].cause    = u_cause[u];
                end
            end
        end
    end

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_dest_i  = '0;
        issue_pc_i    = '0;
        u_valid       = '0;
        u_exc         = '0;
        for (int u = 0; u < 3; u++) begin
            u_tag[u]    = '0;
            u_result[u] = '0;
            u_cause[u]  = EXC_NONE;
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        assert (issue_ready_o) else report_mismatch("issue_ready_o", 32'h1, 32'(issue_ready_o));
        assert (u_ready == 3'b111) else report_mismatch("u_ready", 32'h7, 32'(u_ready));
        assert (issue_tag_o == '0) else report_mismatch("issue_tag_o", 32'h0, 32'(issue_tag_o));
        assert (!writeback_o && !trap_o && !flush_pipeline_o)
            else report_failure("writeback, trap or flush active right after reset");

        // fill the buffer with nothing completing
        while (issued < `ROB_DEPTH) begin
            drive_issue(1'b1);
            @(negedge clk_i);
        end
        drive_issue(1'b0);
        assert (!issue_ready_o) else report_mismatch("issue_ready_o", 32'h0, 32'(issue_ready_o));
        send_result(0, 0, 1'b0);
        while (!issue_ready_o) begin
            @(negedge clk_i);
            step_units(1'b0);
        end
        assert (retired == 1)
            else report_failure("issue_ready_o rose again before the head retired");

        while (issued < N_TOTAL || model.size() != 0) begin
            drive_issue(issued < N_TOTAL && next_random() % 4 != 0);
            step_units(1'b1);
            @(negedge clk_i);
        end
        issue_valid_i = 1'b0;
        u_valid       = '0;

        assert (traps != 0 && retired != 0)
            else report_failure("the run saw no trap or no retirement");
        assert (all_three != 0)
            else report_failure("the three units never presented results in the same cycle");
        $display("No errors");
        $finish;
    end

endmodule : tb_back_end

// ==== list.f ====
+incdir+.
backend_pkg.sv
backend_if.sv
commit_stage.sv
reorder_buffer.sv
retire_stage.sv
back_end.sv
tb_back_end.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_back_end
RTL_TOP   ?= back_end
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
